// File: bench/tb_rob_props.svh
// reorder buffer testbench checks
// concurrent assertions sampled on the rising edge,
// comparing the DUT with the testbench reference model

`ifndef TB_ROB_PROPS_SVH
`define TB_ROB_PROPS_SVH

// ====================
// allocation
// ====================
a_slot0_ptr: assert property (@(posedge clk) disable iff (!rst_n)
  (alloc_req.valid && alloc_rsp.ready && !flush) |-> alloc_rsp.ptr[0] == exp_tail)
  else count_mismatch(1, "slot 0 pointer", $sampled(exp_tail), $sampled(alloc_rsp.ptr[0]));

a_slot1_ptr: assert property (@(posedge clk) disable iff (!rst_n)
  (alloc_req.valid && alloc_rsp.ready && !flush) |->
    alloc_rsp.ptr[1] == PTR_W'(exp_tail + 1))
  else count_mismatch(1, "slot 1 pointer", $sampled(PTR_W'(exp_tail + 1)),
                      $sampled(alloc_rsp.ptr[1]));

// ready follows occupancy only
a_ready: assert property (@(posedge clk) disable iff (!rst_n)
  alloc_rsp.ready == (occ_model <= PTR_W'(FULL_OCC)))
  else count_mismatch(2, "alloc ready", $sampled(occ_model <= PTR_W'(FULL_OCC)),
                      $sampled(alloc_rsp.ready));

// ====================
// retirement
// ====================
for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : gen_slot_chk
  a_pc: assert property (@(posedge clk) disable iff (!rst_n)
    cmt.valid[i] |-> cmt.entry[i].pc == front_pc[i])
    else count_mismatch(3, "retired pc", $sampled(front_pc[i]), $sampled(cmt.entry[i].pc));
  // class, exception flag and destination registers of the retired entry
  a_fields: assert property (@(posedge clk) disable iff (!rst_n)
    cmt.valid[i] |-> {cmt.entry[i].cls, cmt.entry[i].excp.valid, cmt.entry[i].arch_reg,
                      cmt.entry[i].phys_reg} == front_info[i])
    else count_mismatch(3, "retired class, exception and registers",
                        $sampled(front_info[i]),
                        $sampled({cmt.entry[i].cls, cmt.entry[i].excp.valid,
                                  cmt.entry[i].arch_reg, cmt.entry[i].phys_reg}));
  a_done: assert property (@(posedge clk) disable iff (!rst_n)
    cmt.valid[i] |-> front_done[i])
    else count_violation(3, "entry retired before it was completed");
  a_payload: assert property (@(posedge clk) disable iff (!rst_n)
    (cmt.valid[i] && front_wb[i]) |-> cmt.entry[i].payload.rf_data == front_payload[i].rf_data)
    else count_mismatch(4, "payload", $sampled(front_payload[i].rf_data),
                        $sampled(cmt.entry[i].payload.rf_data));
end

a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
  cmt.valid[1] |-> cmt.valid[0])
  else count_violation(3, "slot 1 retired without slot 0");

a_blocking: assert property (@(posedge clk) disable iff (!rst_n)
  (cmt.valid[0] && front_block[0]) |-> !cmt.valid[1])
  else count_violation(4, "slot 1 retired behind an exception or redirect");

a_one_branch: assert property (@(posedge clk) disable iff (!rst_n)
  !(cmt.valid[0] && cmt.valid[1] && front_cls[0] == CLS_BR && front_cls[1] == CLS_BR))
  else count_violation(4, "two branches retired in one cycle");

// ====================
// memory port and flush
// ====================
a_store_head: assert property (@(posedge clk) disable iff (!rst_n)
  (wb_req[MEM_PORT].valid && wb_req[MEM_PORT].cls == CLS_STORE) |->
    wb_rsp[MEM_PORT] == (wb_req[MEM_PORT].idx == exp_head[ROB_IDX_W-1:0]))
  else count_mismatch(5, "store accept",
                      $sampled(wb_req[MEM_PORT].idx == exp_head[ROB_IDX_W-1:0]),
                      $sampled(wb_rsp[MEM_PORT]));

a_load_accept: assert property (@(posedge clk) disable iff (!rst_n)
  (wb_req[MEM_PORT].valid && wb_req[MEM_PORT].cls == CLS_LOAD) |-> wb_rsp[MEM_PORT])
  else count_violation(5, "load writeback was refused");

// ALU ports take every writeback
for (genvar p = 0; p < MEM_PORT; p++) begin : gen_alu_chk
  a_alu_accept: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req[p].valid |-> wb_rsp[p])
    else count_violation(5, "ALU writeback was refused");
end

a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
  flush |=> (cmt.valid == '0 && alloc_rsp.ready))
  else count_violation(6, "buffer not empty or not ready the cycle after flush");

a_flush_ptr: assert property (@(posedge clk) disable iff (!rst_n)
  (post_flush && alloc_req.valid && alloc_rsp.ready && !flush) |-> alloc_rsp.ptr[0] == '0)
  else count_mismatch(6, "first pointer after flush", 0, $sampled(alloc_rsp.ptr[0]));

`endif

// File: bench/tb_rob_top.sv
// reorder buffer testbench
// random allocation and writeback traffic against a
// queue-based reference model, checked by the included
// concurrent assertions, with a fill, drain and flush

`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module tb_rob_top
  import instr_pkg::*;
  import rob_pkg::*;
();

  localparam int MEM_PORT   = `WB_PORTS - 1;
  localparam int FULL_OCC   = `ROB_DEPTH - `DECODE_WIDTH;
  localparam int WAIT_LIMIT = 400;

  typedef struct packed {
    logic [`PC_W-1:0]     pc;
    logic [4:0]           arch_reg;
    logic [5:0]           phys_reg;
    logic [ROB_IDX_W-1:0] idx;
  } order_t;

  logic           clk;
  logic           rst_n;
  logic           flush;
  rob_alloc_req_t alloc_req;
  rob_alloc_rsp_t alloc_rsp;
  rob_wb_req_t    wb_req [`WB_PORTS];
  logic           wb_rsp [`WB_PORTS];
  rob_cmt_t       cmt;

  // reference model
  order_t           order_q [$];
  logic [PTR_W-1:0] exp_tail;
  logic [PTR_W-1:0] exp_head;
  logic [PTR_W-1:0] occ_model;
  instr_class_e     model_cls [`ROB_DEPTH];
  logic             model_done [`ROB_DEPTH];
  logic             model_wb [`ROB_DEPTH];
  logic             model_excp [`ROB_DEPTH];
  wb_payload_u      model_payload [`ROB_DEPTH];
  logic [`PC_W-1:0] front_pc [`COMMIT_WIDTH];
  instr_class_e     front_cls [`COMMIT_WIDTH];
  logic             front_done [`COMMIT_WIDTH];
  logic             front_wb [`COMMIT_WIDTH];
  logic             front_block [`COMMIT_WIDTH];
  wb_payload_u      front_payload [`COMMIT_WIDTH];
  // class, exception flag, arch reg and phys reg
  logic [13:0]      front_info [`COMMIT_WIDTH];
  logic             post_flush;
  bit               alloc_on;
  bit               wb_on;
  bit               flush_req;
  int               pc_seq;
  int               cycles;
  int               errs [1:6];
  int               hits [1:6];
  string            hung;

  rob_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .alloc_req (alloc_req),
    .alloc_rsp (alloc_rsp),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cmt       (cmt)
  );

  always #50 clk = ~clk;

  function automatic string test_name(input int t);
    case (t)
      1: return "alloc_pointers";
      2: return "back_pressure";
      3: return "in_order_retire";
      4: return "retire_rules";
      5: return "store_at_head";
      default: return "flush";
    endcase
  endfunction

  task automatic count_mismatch(input int t, input string what,
                                input longint unsigned exp, input longint unsigned act);
    errs[t]++;
    $display("FAIL %s %s: expected %0h, actual %0h", test_name(t), what, exp, act);
  endtask

  task automatic count_violation(input int t, input string what);
    errs[t]++;
    $display("%s: %s at %0t", test_name(t), what, $time);
  endtask

  // ====================
  // reference model update
  // ====================
  task automatic observe();
    logic [ROB_IDX_W-1:0] idx;
    if (flush) begin
      order_q.delete();
      exp_tail   = '0;
      exp_head   = '0;
      post_flush = 1'b1;
    end else begin
      if (cmt.valid[0] && front_block[0]) hits[4]++;
      if (cmt.valid[1]) hits[3]++;
      if (!alloc_rsp.ready) hits[2]++;
      for (int i = 0; i < `COMMIT_WIDTH; i++) begin
        if (cmt.valid[i] && order_q.size() != 0) begin
          void'(order_q.pop_front());
          exp_head = exp_head + 1'b1;
        end
      end
      if (alloc_req.valid && alloc_rsp.ready) begin
        hits[1]++;
        if (post_flush) hits[6]++;
        post_flush = 1'b0;
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
          if (alloc_req.slot[i].valid) begin
            idx                = exp_tail[ROB_IDX_W-1:0];
            model_cls[idx]     = alloc_req.slot[i].cls;
            model_excp[idx]    = alloc_req.slot[i].excp.valid;
            model_done[idx]    = alloc_req.slot[i].excp.valid;
            model_wb[idx]      = 1'b0;
            model_payload[idx] = '0;
            order_q.push_back(order_t'{alloc_req.slot[i].pc, alloc_req.slot[i].arch_reg,
                                       alloc_req.slot[i].phys_reg, idx});
            exp_tail = exp_tail + 1'b1;
          end
        end
      end
      for (int p = 0; p < `WB_PORTS; p++) begin
        if (wb_req[p].valid && wb_rsp[p]) begin
          idx                = wb_req[p].idx;
          model_done[idx]    = 1'b1;
          model_wb[idx]      = 1'b1;
          model_excp[idx]    = wb_req[p].excp.valid;
          model_payload[idx] = wb_req[p].payload;
        end else if (wb_req[p].valid && wb_req[p].cls == CLS_STORE) begin
          hits[5]++;
        end
      end
    end
    occ_model = exp_tail - exp_head;
    // oldest two entries as commit should see them next cycle
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      front_pc[i]      = '0;
      front_cls[i]     = CLS_ALU;
      front_done[i]    = 1'b0;
      front_wb[i]      = 1'b0;
      front_block[i]   = 1'b0;
      front_payload[i] = '0;
      front_info[i]    = '0;
      if (order_q.size() > i) begin
        idx              = order_q[i].idx;
        front_pc[i]      = order_q[i].pc;
        front_cls[i]     = model_cls[idx];
        front_done[i]    = model_done[idx];
        front_wb[i]      = model_wb[idx];
        front_payload[i] = model_payload[idx];
        front_block[i]   = model_excp[idx] ||
                           (model_cls[idx] == CLS_BR && model_payload[idx].br.redirect);
        front_info[i]    = {model_cls[idx], model_excp[idx],
                            order_q[i].arch_reg, order_q[i].phys_reg};
      end
    end
  endtask

  // ====================
  // stimulus
  // ====================
  task automatic make_alloc(output rob_alloc_req_t req);
    req = '0;
    if (!alloc_on || $urandom_range(3) == 0) return;
    req.valid = 1'b1;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      if (i == 0 || $urandom_range(1) == 1) begin
        req.slot[i].valid      = 1'b1;
        req.slot[i].pc         = `PC_W'(pc_seq * 4);
        req.slot[i].cls        = instr_class_e'($urandom_range(3));
        req.slot[i].excp.valid = ($urandom_range(15) == 0);
        req.slot[i].excp.code  = 6'($urandom_range(63));
        req.slot[i].arch_reg   = 5'($urandom_range(31));
        req.slot[i].phys_reg   = 6'($urandom_range(63));
        pc_seq++;
      end
    end
  endtask

  task automatic make_wb(input logic [ROB_IDX_W-1:0] idx, output rob_wb_req_t w);
    w            = '0;
    w.valid      = 1'b1;
    w.idx        = idx;
    w.cls        = model_cls[idx];
    w.excp.valid = ($urandom_range(31) == 0);
    w.excp.code  = 6'($urandom_range(63));
    if (model_cls[idx] == CLS_BR) begin
      w.payload.br.redirect = ($urandom_range(3) == 0);
      w.payload.br.taken    = $urandom_range(1);
      w.payload.br.target   = 30'($urandom);
    end else begin
      w.payload.rf_data = $urandom;
    end
  endtask

  task automatic drive();
    rob_alloc_req_t       req;
    rob_wb_req_t          w;
    int                   cand [$];
    int                   pick;
    logic [ROB_IDX_W-1:0] idx;
    bit                   found;
    flush <= flush_req;
    if (flush_req) begin
      flush_req = 1'b0;
      alloc_req <= '0;
      for (int p = 0; p < `WB_PORTS; p++) wb_req[p] <= '0;
      return;
    end
    // a refused group is held until ready
    if (!(alloc_req.valid && !alloc_rsp.ready)) begin
      make_alloc(req);
      alloc_req <= req;
    end
    foreach (order_q[k]) begin
      idx = order_q[k].idx;
      if (!model_done[idx] && model_cls[idx] inside {CLS_ALU, CLS_BR}) cand.push_back(idx);
    end
    for (int p = 0; p < MEM_PORT; p++) begin
      w = '0;
      if (wb_on && cand.size() != 0 && $urandom_range(3) != 0) begin
        pick = $urandom_range(cand.size() - 1);
        make_wb(cand[pick], w);
        cand.delete(pick);
      end
      wb_req[p] <= w;
    end
    // memory port serves the oldest open load or store, a refused store waits
    if (!(wb_req[MEM_PORT].valid && !wb_rsp[MEM_PORT])) begin
      w     = '0;
      found = 1'b0;
      if (wb_on && $urandom_range(1) == 1) begin
        for (int k = 0; k < order_q.size(); k++) begin
          idx = order_q[k].idx;
          if (!found && !model_done[idx] && model_cls[idx] inside {CLS_LOAD, CLS_STORE}) begin
            found = 1'b1;
            make_wb(idx, w);
          end
        end
      end
      wb_req[MEM_PORT] <= w;
    end
  endtask

  task automatic step();
    @(posedge clk);
    cycles++;
    observe();
    drive();
  endtask

  task automatic finish_test(input int t);
    if (hits[t] == 0) begin
      errs[t]++;
      $display("%s: stimulus never reached this check", test_name(t));
    end
    $display("test %0d %s %s, hits %0d, errors %0d", t, test_name(t),
             errs[t] == 0 ? "ok" : "failed", hits[t], errs[t]);
  endtask

  task automatic run_tests();
    int n;
    alloc_on = 1'b1;
    wb_on    = 1'b1;
    repeat (200) step();
    finish_test(1);
    // fill with writebacks held back, then let it drain below the limit
    wb_on = 1'b0;
    for (n = 0; n < WAIT_LIMIT && occ_model <= PTR_W'(FULL_OCC); n++) step();
    if (occ_model <= PTR_W'(FULL_OCC)) begin
      hung = "buffer never filled while writebacks were held";
      return;
    end
    repeat (5) step();
    wb_on = 1'b1;
    for (n = 0; n < WAIT_LIMIT && occ_model > PTR_W'(FULL_OCC); n++) step();
    if (occ_model > PTR_W'(FULL_OCC)) begin
      hung = "alloc ready never recovered after retirement";
      return;
    end
    finish_test(2);
    repeat (1500) step();
    alloc_on = 1'b0;
    for (n = 0; n < WAIT_LIMIT && occ_model != 0; n++) step();
    if (occ_model != 0) begin
      hung = "buffer never drained";
      return;
    end
    finish_test(3);
    finish_test(4);
    finish_test(5);
    alloc_on = 1'b1;
    repeat (30) step();
    flush_req = 1'b1;
    repeat (12) step();
    finish_test(6);
  endtask

  initial begin
    int total;
    void'($urandom(32'h44ef));
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    alloc_req  = '0;
    for (int p = 0; p < `WB_PORTS; p++) wb_req[p] = '0;
    exp_tail   = '0;
    exp_head   = '0;
    occ_model  = '0;
    post_flush = 1'b0;
    flush_req  = 1'b0;
    pc_seq     = 1;
    cycles     = 0;
    hung       = "";
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      model_cls[i]     = CLS_ALU;
      model_done[i]    = 1'b0;
      model_wb[i]      = 1'b0;
      model_excp[i]    = 1'b0;
      model_payload[i] = '0;
    end
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      front_pc[i]      = '0;
      front_cls[i]     = CLS_ALU;
      front_done[i]    = 1'b0;
      front_wb[i]      = 1'b0;
      front_block[i]   = 1'b0;
      front_payload[i] = '0;
      front_info[i]    = '0;
    end
    for (int t = 1; t <= 6; t++) begin
      errs[t] = 0;
      hits[t] = 0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    run_tests();
    total = 0;
    for (int t = 1; t <= 6; t++) total += errs[t];
    $display("tests 6, cycles %0d, errors %0d", cycles, total);
    if (hung.len() == 0 && total == 0) begin
      $display(">>> PASS");
    end else begin
      if (hung.len() != 0) $display("timeout: %s", hung);
      $display(">>> FAIL");
    end
    $finish;
  end

  `include "tb_rob_props.svh"

endmodule

`default_nettype wire

// File: common/instr_pkg.sv
// instruction-level types
// instruction class, exception record and the
// writeback payload word shared by writeback and commit

`default_nettype none

package instr_pkg;

  // ====================
  // classification
  // ====================
  typedef enum logic [1:0] {
    CLS_ALU   = 2'd0,
    CLS_BR    = 2'd1,
    CLS_LOAD  = 2'd2,
    CLS_STORE = 2'd3
  } instr_class_e;

  typedef struct packed {
    logic       valid;
    logic [5:0] code;
  } excp_t;

  // ====================
  // writeback payload
  // ====================
  // branch view, target is word aligned
  typedef struct packed {
    logic        redirect;
    logic        taken;
    logic [29:0] target;
  } br_fields_t;

  // one word, decoded by the entry class at commit
  typedef union packed {
    logic [31:0] rf_data;
    br_fields_t  br;
  } wb_payload_u;

endpackage

`default_nettype wire

// File: common/rob_cfg.svh
// reorder buffer configuration
// sizes shared by the ROB packages and RTL
// ROB_DEPTH must stay a power of two, the
// banked storage splits it evenly by COMMIT_WIDTH

`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// ====================
// buffer geometry
// ====================
`define ROB_DEPTH 16

// allocation slots per cycle
`define DECODE_WIDTH 2

// retire slots per cycle, also the bank count
`define COMMIT_WIDTH 2

// two ALU ports then the memory port last
`define WB_PORTS 3

`define PC_W 32

`endif

// File: common/rob_pkg.sv
// reorder buffer types
// pointers, entries and the request/response structs
// used between decode, writeback, the banks and commit

`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;
  import instr_pkg::*;

  localparam int ROB_IDX_W = $clog2(`ROB_DEPTH);
  localparam int PTR_W     = ROB_IDX_W + 1;
  // low index bits pick the bank, the rest the row
  localparam int BANK_W    = $clog2(`COMMIT_WIDTH);
  localparam int ROW_W     = ROB_IDX_W - BANK_W;

  // index plus wrap bit
  typedef struct packed {
    logic                 wrap;
    logic [ROB_IDX_W-1:0] idx;
  } rob_ptr_t;

  typedef logic [ROW_W-1:0] rob_row_t;

  typedef struct packed {
    logic            complete;
    logic [`PC_W-1:0] pc;
    instr_class_e    cls;
    excp_t           excp;
    wb_payload_u     payload;
    logic [4:0]      arch_reg;
    logic [5:0]      phys_reg;
  } rob_entry_t;

  // ====================
  // allocation
  // ====================
  typedef struct packed {
    logic             valid;
    logic [`PC_W-1:0] pc;
    instr_class_e     cls;
    excp_t            excp;
    logic [4:0]       arch_reg;
    logic [5:0]       phys_reg;
  } rob_alloc_slot_t;

  typedef struct packed {
    logic                                 valid;
    rob_alloc_slot_t [`DECODE_WIDTH-1:0] slot;
  } rob_alloc_req_t;

  typedef struct packed {
    logic                          ready;
    rob_ptr_t [`DECODE_WIDTH-1:0] ptr;
  } rob_alloc_rsp_t;

  // ====================
  // writeback and banks
  // ====================
  typedef struct packed {
    logic                 valid;
    logic [ROB_IDX_W-1:0] idx;
    instr_class_e         cls;
    excp_t                excp;
    wb_payload_u          payload;
  } rob_wb_req_t;

  // one completion lane per writeback port
  typedef struct packed {
    logic        valid;
    rob_row_t    row;
    excp_t       excp;
    wb_payload_u payload;
  } bank_cpl_t;

  typedef struct packed {
    logic                        alloc_valid;
    rob_row_t                    alloc_row;
    rob_entry_t                  alloc_entry;
    bank_cpl_t [`WB_PORTS-1:0]   cpl;
  } bank_wr_t;

  typedef struct packed {
    logic       [`COMMIT_WIDTH-1:0] valid;
    rob_entry_t [`COMMIT_WIDTH-1:0] entry;
  } rob_cmt_t;

endpackage

`default_nettype wire

// File: design/rob_top.sv
// banked reorder buffer top level
// dispatch feeds COMMIT_WIDTH interleaved banks,
// commit drains them in program order

`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module rob_top
  import rob_pkg::*;
(
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           flush,
  input  wire rob_alloc_req_t alloc_req,
  output rob_alloc_rsp_t      alloc_rsp,
  input  wire rob_wb_req_t    wb_req [`WB_PORTS],
  output logic                wb_rsp [`WB_PORTS],
  output rob_cmt_t            cmt
);

  rob_ptr_t   head;
  rob_ptr_t   tail;
  bank_wr_t   bank_wr [`COMMIT_WIDTH];
  rob_row_t   rd_row [`COMMIT_WIDTH];
  rob_entry_t bank_entry [`COMMIT_WIDTH];

  rob_dispatch dispatch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .alloc_req (alloc_req),
    .alloc_rsp (alloc_rsp),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .head      (head),
    .tail      (tail),
    .bank_wr   (bank_wr)
  );

  // even indices in bank 0, odd in bank 1
  for (genvar b = 0; b < `COMMIT_WIDTH; b++) begin : gen_bank
    rob_bank bank_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .wr       (bank_wr[b]),
      .rd_row   (rd_row[b]),
      .rd_entry (bank_entry[b])
    );
  end

  rob_commit commit_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .tail       (tail),
    .bank_entry (bank_entry),
    .rd_row     (rd_row),
    .head       (head),
    .cmt        (cmt)
  );

endmodule

`default_nettype wire

// File: rob/rob_bank.sv
// reorder buffer storage bank
// holds every entry whose index maps to this bank
// new entries are written on allocation, completions
// merge exception and payload and set the complete flag
// the head row is read back combinationally

`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module rob_bank
  import rob_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     flush,
  input  wire bank_wr_t wr,
  input  wire rob_row_t rd_row,
  output rob_entry_t    rd_entry
);

  localparam int ROWS = `ROB_DEPTH / `COMMIT_WIDTH;

  rob_entry_t      entries [ROWS];
  logic [ROWS-1:0] done_q;
  logic            row_clash;

  // ====================
  // entry payload
  // ====================
  always_ff @(posedge clk) begin
    if (wr.alloc_valid) begin
      entries[wr.alloc_row] <= wr.alloc_entry;
    end
    for (int p = 0; p < `WB_PORTS; p++) begin
      if (wr.cpl[p].valid) begin
        entries[wr.cpl[p].row].excp    <= wr.cpl[p].excp;
        entries[wr.cpl[p].row].payload <= wr.cpl[p].payload;
      end
    end
  end

  // ====================
  // complete flags
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= '0;
    end else if (flush) begin
      done_q <= '0;
    end else begin
      if (wr.alloc_valid) begin
        done_q[wr.alloc_row] <= wr.alloc_entry.complete;
      end
      for (int p = 0; p < `WB_PORTS; p++) begin
        if (wr.cpl[p].valid) begin
          done_q[wr.cpl[p].row] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    rd_entry          = entries[rd_row];
    rd_entry.complete = done_q[rd_row];
  end

  // any two writes landing on one row this cycle
  always_comb begin
    row_clash = 1'b0;
    for (int p = 0; p < `WB_PORTS; p++) begin
      if (wr.cpl[p].valid && wr.alloc_valid && wr.cpl[p].row == wr.alloc_row) begin
        row_clash = 1'b1;
      end
      for (int q = p + 1; q < `WB_PORTS; q++) begin
        if (wr.cpl[p].valid && wr.cpl[q].valid && wr.cpl[p].row == wr.cpl[q].row) begin
          row_clash = 1'b1;
        end
      end
    end
  end

  // decode and the writeback units must not target one entry together
  a_no_row_clash: assert property (
    @(posedge clk) disable iff (!rst_n) !row_clash
  ) else $error("two writes to one bank row in a cycle");

endmodule

`default_nettype wire

// File: rob/rob_commit.sv
// reorder buffer commit side
// owns the head pointer, reads the oldest entries from
// the banks and retires up to COMMIT_WIDTH in order
// exceptions and redirects retire alone from slot 0,
// and only one branch leaves per cycle

`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module rob_commit
  import instr_pkg::*;
  import rob_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       flush,
  input  wire rob_ptr_t   tail,
  input  wire rob_entry_t bank_entry [`COMMIT_WIDTH],
  output rob_row_t        rd_row [`COMMIT_WIDTH],
  output rob_ptr_t        head,
  output rob_cmt_t        cmt
);

  rob_ptr_t                 head_q;
  rob_ptr_t                 head_d;
  rob_ptr_t                 slot_ptr [`COMMIT_WIDTH];
  rob_entry_t               slot_entry [`COMMIT_WIDTH];
  logic [PTR_W-1:0]         occupancy;
  logic [PTR_W-1:0]         retire_cnt;
  logic [`COMMIT_WIDTH-1:0] slot_valid;
  logic [`COMMIT_WIDTH-1:0] is_br;
  logic [`COMMIT_WIDTH-1:0] blocks;
  logic [`COMMIT_WIDTH-1:0] retire;
  logic                     br_seen;

  // ====================
  // head row read
  // ====================
  always_comb begin
    occupancy = tail - head_q;
    for (int b = 0; b < `COMMIT_WIDTH; b++) begin
      rd_row[b] = '0;
    end
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      slot_ptr[i] = head_q + PTR_W'(i);
      // rotate bank outputs so slot 0 is always the head
      rd_row[slot_ptr[i].idx[BANK_W-1:0]] = slot_ptr[i].idx[ROB_IDX_W-1:BANK_W];
      slot_entry[i] = bank_entry[slot_ptr[i].idx[BANK_W-1:0]];
      slot_valid[i] = occupancy > PTR_W'(i);
      is_br[i]      = slot_entry[i].cls == CLS_BR;
      // redirect bit only means something for branches
      blocks[i]     = slot_entry[i].excp.valid |
                      (is_br[i] & slot_entry[i].payload.br.redirect);
    end
  end

  // ====================
  // retire masks
  // ====================
  always_comb begin
    retire[0]  = slot_valid[0] & slot_entry[0].complete;
    br_seen    = is_br[0];
    retire_cnt = PTR_W'(retire[0]);
    for (int i = 1; i < `COMMIT_WIDTH; i++) begin
      retire[i] = retire[i-1] & slot_valid[i] & slot_entry[i].complete &
                  ~blocks[i-1] & ~blocks[i] & ~(is_br[i] & br_seen);
      br_seen    = br_seen | is_br[i];
      retire_cnt = retire_cnt + PTR_W'(retire[i]);
    end
    head_d = head_q + retire_cnt;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
    end else if (flush) begin
      head_q <= '0;
    end else begin
      head_q <= head_d;
    end
  end

  assign head = head_q;

  always_comb begin
    cmt.valid = retire;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      cmt.entry[i] = slot_entry[i];
    end
  end

  // retiring must leave head at or behind the dispatch tail
  a_head_behind_tail: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|retire && !flush) |=> occupancy <= PTR_W'(`ROB_DEPTH)
  ) else $error("head passed tail, distance %0d", occupancy);

endmodule

`default_nettype wire

// File: rob/rob_dispatch.sv
// reorder buffer dispatch side
// owns the tail pointer, grants allocations while the
// buffer has room for a full decode group and routes
// accepted writebacks to the interleaved banks
// memory writebacks other than loads wait for the head

`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module rob_dispatch
  import instr_pkg::*;
  import rob_pkg::*;
(
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           flush,
  input  wire rob_alloc_req_t alloc_req,
  output rob_alloc_rsp_t      alloc_rsp,
  input  wire rob_wb_req_t    wb_req [`WB_PORTS],
  output logic                wb_rsp [`WB_PORTS],
  input  wire rob_ptr_t       head,
  output rob_ptr_t            tail,
  output bank_wr_t            bank_wr [`COMMIT_WIDTH]
);

  localparam int MEM_PORT = `WB_PORTS - 1;

  rob_ptr_t         tail_q;
  rob_ptr_t         tail_d;
  rob_ptr_t         slot_ptr [`DECODE_WIDTH];
  rob_entry_t       new_entry [`DECODE_WIDTH];
  logic [PTR_W-1:0] occupancy;
  logic [PTR_W-1:0] alloc_cnt;
  logic             alloc_fire;

  // ====================
  // allocation
  // ====================
  assign occupancy = tail_q - head;

  always_comb begin
    // ready never looks at the request
    alloc_rsp.ready = occupancy <= PTR_W'(`ROB_DEPTH - `DECODE_WIDTH);
    alloc_fire      = alloc_req.valid & alloc_rsp.ready & ~flush;
    alloc_cnt       = '0;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      slot_ptr[i]      = tail_q + PTR_W'(i);
      alloc_rsp.ptr[i] = slot_ptr[i];
      if (alloc_req.slot[i].valid) begin
        alloc_cnt = alloc_cnt + PTR_W'(1);
      end
      // faulting instructions arrive already complete
      new_entry[i].complete = alloc_req.slot[i].excp.valid;
      new_entry[i].pc       = alloc_req.slot[i].pc;
      new_entry[i].cls      = alloc_req.slot[i].cls;
      new_entry[i].excp     = alloc_req.slot[i].excp;
      new_entry[i].payload  = '0;
      new_entry[i].arch_reg = alloc_req.slot[i].arch_reg;
      new_entry[i].phys_reg = alloc_req.slot[i].phys_reg;
    end
    tail_d = alloc_fire ? rob_ptr_t'(tail_q + alloc_cnt) : tail_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_q <= '0;
    end else if (flush) begin
      tail_q <= '0;
    end else begin
      tail_q <= tail_d;
    end
  end

  assign tail = tail_q;

  // ====================
  // writeback accept
  // ====================
  always_comb begin
    for (int p = 0; p < MEM_PORT; p++) begin
      wb_rsp[p] = 1'b1;
    end
    // stores and other side effects only once oldest
    wb_rsp[MEM_PORT] = (wb_req[MEM_PORT].cls == CLS_LOAD) ||
                       (wb_req[MEM_PORT].idx == head.idx);
  end

  // steer allocation slots and completions by low index bits
  always_comb begin
    for (int b = 0; b < `COMMIT_WIDTH; b++) begin
      bank_wr[b] = '0;
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        if (alloc_fire && alloc_req.slot[i].valid &&
            slot_ptr[i].idx[BANK_W-1:0] == BANK_W'(b)) begin
          bank_wr[b].alloc_valid = 1'b1;
          bank_wr[b].alloc_row   = slot_ptr[i].idx[ROB_IDX_W-1:BANK_W];
          bank_wr[b].alloc_entry = new_entry[i];
        end
      end
      for (int p = 0; p < `WB_PORTS; p++) begin
        bank_wr[b].cpl[p].valid   = wb_req[p].valid && wb_rsp[p] && !flush &&
                                    wb_req[p].idx[BANK_W-1:0] == BANK_W'(b);
        bank_wr[b].cpl[p].row     = wb_req[p].idx[ROB_IDX_W-1:BANK_W];
        bank_wr[b].cpl[p].excp    = wb_req[p].excp;
        bank_wr[b].cpl[p].payload = wb_req[p].payload;
      end
    end
  end

  // the commit side must never let the buffer hold more than its depth
  a_no_overrun: assert property (
    @(posedge clk) disable iff (!rst_n)
    alloc_fire |=> occupancy <= PTR_W'(`ROB_DEPTH)
  ) else $error("rob overrun, occupancy %0d", occupancy);

endmodule

`default_nettype wire

// File: rob_top.f
+incdir+common
+incdir+bench
common/instr_pkg.sv
common/rob_pkg.sv
rob/rob_dispatch.sv
rob/rob_bank.sv
rob/rob_commit.sv
design/rob_top.sv
bench/tb_rob_top.sv
